// ==== logic/squeeze_pkg.sv ====
// Sizes are scaled for simulation; arithmetic assumes sums stay inside 29 bits before requantization
`default_nettype none

package squeeze_pkg;

	//////////////////////////////////////////////////////////////////////
	// Layer sizes
	//////////////////////////////////////////////////////////////////////

	// One lane per output channel
	localparam int LANES = 4;
	// Kernel area 1x1 times 16 input channels
	localparam int TAPS = 16;
	// 3 by 3 output map
	localparam int PIXELS = 9;
	// Tap addresses from here on live in the distributed bank
	localparam int BANK_SPLIT = 12;
	localparam int DIST_DEPTH = TAPS - BANK_SPLIT;
	localparam int DIST_W = $clog2(DIST_DEPTH);

	localparam int TAP_W = $clog2(TAPS);
	localparam int PIX_W = $clog2(PIXELS);

	//////////////////////////////////////////////////////////////////////
	// Fixed-point format
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_W = 16;
	localparam int ACC_W = 32;
	// Fraction bits dropped when going back to 16 bits
	localparam int FRAC = 14;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef data_t [LANES-1:0] kern_vec_t;
	typedef data_t [LANES-1:0] ofm_vec_t;
	typedef logic [TAP_W-1:0] tap_addr_t;
	typedef logic [PIX_W-1:0] pix_idx_t;

	// Layer to store, vector valid while sample is high
	typedef struct packed {
		logic sample;
		ofm_vec_t vec;
	} ofm_beat_t;

	//////////////////////////////////////////////////////////////////////
	// Weight, bias and requantization rules
	//////////////////////////////////////////////////////////////////////

	// Mixed lane and tap, range -6 to 6
	function automatic data_t weight_of(input int lane, input int tap);
		int v;
		v = ((lane * 5 + tap * 3 + 1) % 13) - 6;
		return data_t'(v);
	endfunction

	// Odd lanes get a negative bias
	function automatic acc_t bias_of(input int lane);
		acc_t b;
		if (lane % 2 == 1)
			b = -acc_t'((lane + 1) * 3000);
		else
			b = acc_t'((lane + 1) * 20000 + 777);
		return b;
	endfunction

	// ReLU, then keep bits 28 down to 14 under a zero sign bit
	function automatic data_t requant(input acc_t sum);
		data_t q;
		if (sum[ACC_W-1])
			q = '0;
		else
			q = {1'b0, sum[FRAC+DATA_W-2:FRAC]};
		return q;
	endfunction

endpackage

`default_nettype wire

// ==== logic/weight_rom.sv ====
// Contents fixed at elaboration from weight_of; both banks answer one cycle after the address
`timescale 1ns/10ps
`default_nettype none

module weight_rom (
	input logic clk,
	input squeeze_pkg::tap_addr_t address,
	output squeeze_pkg::kern_vec_t weights
);
	import squeeze_pkg::*;

	// Block bank, low addresses
	kern_vec_t blk_mem [BANK_SPLIT];
	kern_vec_t blk_q;

	// Distributed bank, the rest
	kern_vec_t dist_mem [DIST_DEPTH];
	logic [DIST_W-1:0] dist_idx;
	kern_vec_t dist_rd;
	kern_vec_t dist_q;

	// High when the registered word came from the distributed bank
	logic sel_q;

	initial begin
		for (int a = 0; a < BANK_SPLIT; a++)
			for (int l = 0; l < LANES; l++)
				blk_mem[a][l] = weight_of(l, a);
		for (int a = 0; a < DIST_DEPTH; a++)
			for (int l = 0; l < LANES; l++)
				dist_mem[a][l] = weight_of(l, a + BANK_SPLIT);
	end

	// Synchronous read, only for addresses it owns
	always_ff @(posedge clk) begin
		if (address < tap_addr_t'(BANK_SPLIT))
			blk_q <= blk_mem[address];
	end

	// Offset into the distributed bank
	assign dist_idx = DIST_W'(address - tap_addr_t'(BANK_SPLIT));
	assign dist_rd = dist_mem[dist_idx];

	// Combinational read then one register
	always_ff @(posedge clk) begin
		dist_q <= dist_rd;
		sel_q <= (address >= tap_addr_t'(BANK_SPLIT));
	end

	// Both paths line up on the same edge
	assign weights = sel_q ? dist_q : blk_q;

endmodule

`default_nettype wire

// ==== logic/mac_lane.sv ====
// Clear must arrive in the cycle after the last product of a pixel was accumulated
`timescale 1ns/10ps
`default_nettype none

module mac_lane (
	input logic clk,
	input logic reset,
	input logic layer_en,
	input logic clr,
	input squeeze_pkg::data_t pix,
	input squeeze_pkg::data_t ker,
	output squeeze_pkg::acc_t mul_out
);
	import squeeze_pkg::*;

	acc_t prod;
	logic prod_vld;
	acc_t acc;

	// Product stage
	always_ff @(posedge clk) begin
		prod <= acc_t'(pix) * acc_t'(ker);
	end

	// Product valid follows the enable
	always_ff @(posedge clk) begin
		if (reset)
			prod_vld <= 1'b0;
		else
			prod_vld <= layer_en;
	end

	// On clear the sum restarts with the product now in flight
	always_ff @(posedge clk) begin
		if (reset)
			acc <= '0;
		else if (clr)
			acc <= prod_vld ? prod : '0;
		else if (prod_vld)
			acc <= acc + prod;
	end

	// Finished sum while clr is high
	assign mul_out = acc;

endmodule

`default_nettype wire

// ==== logic/squeeze_layer.sv ====
// Expects one tap per cycle with layer_en high; no back-pressure, and stops after PIXELS samples
`timescale 1ns/10ps
`default_nettype none

module squeeze_layer (
	input logic clk,
	input logic reset,
	input logic layer_en,
	input squeeze_pkg::data_t ifm,
	input logic ram_feedback,
	output squeeze_pkg::ofm_beat_t beat,
	output logic finish
);
	import squeeze_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Input alignment
	//////////////////////////////////////////////////////////////////////

	// Tap in cycle t reaches the lanes in t+2 together with its weight
	data_t ifm_d1;
	data_t ifm_d2;
	logic en_d1;
	logic en_d2;

	tap_addr_t rom_addr;
	kern_vec_t rom_weights;
	kern_vec_t kern_q;

	tap_addr_t tap_cnt;
	logic clr_int;
	logic clr_d1;
	logic clr_lane;

	acc_t lane_sum [LANES];
	acc_t biased [LANES];

	logic sample_q;
	ofm_vec_t vec_q;
	pix_idx_t pix_cnt;
	logic layer_end;
	logic fb_latched;

	always_ff @(posedge clk) begin
		ifm_d1 <= ifm;
		ifm_d2 <= ifm_d1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			en_d1 <= 1'b0;
			en_d2 <= 1'b0;
		end else begin
			en_d1 <= layer_en;
			en_d2 <= en_d1;
		end
	end

	// Address of the tap being presented now
	always_ff @(posedge clk) begin
		if (reset)
			rom_addr <= '0;
		else if (layer_en && !layer_end)
			rom_addr <= (rom_addr == tap_addr_t'(TAPS - 1)) ? '0 : rom_addr + 1'b1;
	end

	weight_rom rom_inst (
		.clk(clk),
		.address(rom_addr),
		.weights(rom_weights)
	);

	// Kernel register
	always_ff @(posedge clk) begin
		kern_q <= rom_weights;
	end

	//////////////////////////////////////////////////////////////////////
	// Clear generation
	//////////////////////////////////////////////////////////////////////

	// One-cycle pulse after TAPS taps, frozen once the layer is done
	always_ff @(posedge clk) begin
		if (reset) begin
			tap_cnt <= '0;
			clr_int <= 1'b0;
		end else begin
			clr_int <= 1'b0;
			if (en_d1 && !layer_end) begin
				if (tap_cnt == tap_addr_t'(TAPS - 1)) begin
					tap_cnt <= '0;
					clr_int <= 1'b1;
				end else begin
					tap_cnt <= tap_cnt + 1'b1;
				end
			end
		end
	end

	// Two more stages so clear meets the completed sums
	always_ff @(posedge clk) begin
		if (reset) begin
			clr_d1 <= 1'b0;
			clr_lane <= 1'b0;
		end else begin
			clr_d1 <= clr_int;
			clr_lane <= clr_d1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Lane array
	//////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		mac_lane lane_inst (
			.clk(clk),
			.reset(reset),
			.layer_en(en_d2),
			.clr(clr_lane),
			.pix(ifm_d2),
			.ker(kern_q[g]),
			.mul_out(lane_sum[g])
		);
	end

	// Per-lane bias
	always_comb begin
		for (int i = 0; i < LANES; i++)
			biased[i] = lane_sum[i] + bias_of(i);
	end

	// ReLU and requantization, captured with the clear
	always_ff @(posedge clk) begin
		if (clr_lane)
			for (int i = 0; i < LANES; i++)
				vec_q[i] <= requant(biased[i]);
	end

	// Fixed latency: four edges after the edge taking the last tap
	always_ff @(posedge clk) begin
		if (reset)
			sample_q <= 1'b0;
		else
			sample_q <= clr_lane && !layer_end;
	end

	assign beat = '{sample: sample_q, vec: vec_q};

	//////////////////////////////////////////////////////////////////////
	// Pixel timer and finish
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt <= '0;
			layer_end <= 1'b0;
		end else if (sample_q && !layer_end) begin
			if (pix_cnt == pix_idx_t'(PIXELS - 1))
				layer_end <= 1'b1;
			else
				pix_cnt <= pix_cnt + 1'b1;
		end
	end

	// Next stage has taken the map, hold finish low until reset
	always_ff @(posedge clk) begin
		if (reset)
			fb_latched <= 1'b0;
		else if (ram_feedback)
			fb_latched <= 1'b1;
	end

	assign finish = layer_end && !fb_latched;

endmodule

`default_nettype wire

// ==== logic/ofm_store.sv ====
// Always accepts; holds one run of PIXELS vectors and wraps if more samples arrive
`timescale 1ns/10ps
`default_nettype none

module ofm_store (
	input logic clk,
	input logic reset,
	input squeeze_pkg::ofm_beat_t beat,
	input squeeze_pkg::pix_idx_t rd_addr,
	output squeeze_pkg::ofm_vec_t rd_data
);
	import squeeze_pkg::*;

	ofm_vec_t mem [PIXELS];
	pix_idx_t wr_ptr;

	// Next free pixel slot
	always_ff @(posedge clk) begin
		if (reset)
			wr_ptr <= '0;
		else if (beat.sample)
			wr_ptr <= (wr_ptr == pix_idx_t'(PIXELS - 1)) ? '0 : wr_ptr + 1'b1;
	end

	// Write in the sample cycle
	always_ff @(posedge clk) begin
		if (beat.sample)
			mem[wr_ptr] <= beat.vec;
	end

	// Registered read, out-of-range addresses keep the last word
	always_ff @(posedge clk) begin
		if (rd_addr < pix_idx_t'(PIXELS))
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== logic/squeeze_top.sv ====
// Read side sees a vector from the cycle after its sample; rd_data lags rd_addr by one cycle
`timescale 1ns/10ps
`default_nettype none

module squeeze_top (
	input logic clk,
	input logic reset,
	input logic layer_en,
	input squeeze_pkg::data_t ifm,
	input logic ram_feedback,
	input squeeze_pkg::pix_idx_t rd_addr,
	output squeeze_pkg::ofm_vec_t rd_data,
	output logic sample,
	output logic finish
);
	import squeeze_pkg::*;

	// Layer output toward the store
	ofm_beat_t beat;

	squeeze_layer layer_inst (
		.clk(clk),
		.reset(reset),
		.layer_en(layer_en),
		.ifm(ifm),
		.ram_feedback(ram_feedback),
		.beat(beat),
		.finish(finish)
	);

	ofm_store store_inst (
		.clk(clk),
		.reset(reset),
		.beat(beat),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	// Sample pulse also goes out
	assign sample = beat.sample;

endmodule

`default_nettype wire

// ==== bench/squeeze_assertions.sv ====
// Bound into squeeze_top; keeps its own sample count and latches, all cleared by reset
`timescale 1ns/10ps
`default_nettype none

module squeeze_assertions (
	input logic clk,
	input logic reset,
	input logic sample,
	input logic finish,
	input logic ram_feedback
);
	import squeeze_pkg::*;

	int samples_seen;
	logic fb_seen;
	logic finish_seen;
	// Read by the testbench at the end
	int fail_count = 0;

	always_ff @(posedge clk) begin
		if (reset) begin
			samples_seen <= 0;
			fb_seen <= 1'b0;
			finish_seen <= 1'b0;
		end else begin
			if (sample)
				samples_seen <= samples_seen + 1;
			if (ram_feedback)
				fb_seen <= 1'b1;
			if (finish)
				finish_seen <= 1'b1;
		end
	end

	// Single-cycle pulse
	assert property (@(posedge clk) disable iff (reset) sample |=> !sample)
		else begin
			fail_count++;
			$error("sample stayed high for two cycles");
		end

	// No finish before the full map
	assert property (@(posedge clk) disable iff (reset) (samples_seen < PIXELS) |-> !finish)
		else begin
			fail_count++;
			$error("finish rose after only %0d samples", samples_seen);
		end

	// Feedback ends finish for good
	assert property (@(posedge clk) disable iff (reset) fb_seen |-> !finish)
		else begin
			fail_count++;
			$error("finish high after ram_feedback");
		end

	assert property (@(posedge clk) disable iff (reset) (finish || finish_seen) |-> !sample)
		else begin
			fail_count++;
			$error("sample seen after finish");
		end

endmodule

bind squeeze_top squeeze_assertions assertions_inst (
	.clk(clk),
	.reset(reset),
	.sample(sample),
	.finish(finish),
	.ram_feedback(ram_feedback)
);

`default_nettype wire

// ==== bench/squeeze_model.svh ====
// Reference arithmetic for the testbench; needs squeeze_pkg imported in the including module
`ifndef SQUEEZE_MODEL_SVH
`define SQUEEZE_MODEL_SVH

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state;

// Pixel stream of one run, taps in order within each pixel
data_t stream [PIXELS][TAPS];

// One step gives one bit
function automatic logic lfsr_bit();
	logic out_bit;
	out_bit = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (out_bit)
		lfsr_state = lfsr_state ^ 16'hB400;
	return out_bit;
endfunction

// n bits, first bit ends up as the MSB
function automatic logic [31:0] lfsr_take(input int n);
	logic [31:0] val;
	val = '0;
	for (int i = 0; i < n; i++)
		val = {val[30:0], lfsr_bit()};
	return val;
endfunction

// ReLU, then drop FRAC bits and keep 15 bits under a zero sign
function automatic data_t model_requant(input longint sum);
	longint shifted;
	if (sum < 0)
		return '0;
	shifted = (sum >>> FRAC) & 64'h7FFF;
	return data_t'(shifted);
endfunction

// Full dot product over the pixel's taps plus bias, per lane
function automatic ofm_vec_t expected_vec(input int p);
	ofm_vec_t v;
	longint sum;
	for (int l = 0; l < LANES; l++) begin
		sum = longint'(bias_of(l));
		for (int t = 0; t < TAPS; t++)
			sum += longint'(stream[p][t]) * longint'(weight_of(l, t));
		v[l] = model_requant(sum);
	end
	return v;
endfunction

`endif

// ==== bench/squeeze_tb.sv ====
// Directed tests only; every test starts from reset and the run stops at the first mismatch
`timescale 1ns/10ps
`default_nettype none

module squeeze_tb;
	import squeeze_pkg::*;

	// Cycles allowed for any single wait
	localparam int WAIT_LIMIT = 400;

	logic clk;
	logic reset;
	logic layer_en;
	data_t ifm;
	logic ram_feedback;
	pix_idx_t rd_addr;
	ofm_vec_t rd_data;
	logic sample;
	logic finish;

	// Samples since reset counted on the rising edge
	int sample_count;

	`include "squeeze_model.svh"

	squeeze_top squeeze_top_inst (
		.clk(clk),
		.reset(reset),
		.layer_en(layer_en),
		.ifm(ifm),
		.ram_feedback(ram_feedback),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.sample(sample),
		.finish(finish)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always_ff @(posedge clk) begin
		if (reset)
			sample_count <= 0;
		else if (sample)
			sample_count <= sample_count + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic signed [63:0] got,
			input logic signed [63:0] expected);
		if (got !== expected) begin
			$display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, expected);
			$display("Something failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Waited %0d cycles for %s and it never came", WAIT_LIMIT, what);
		$display("Something failed");
		$fatal(1, "Timeout on %s", what);
	endtask

	// Four rising edges with reset high and all inputs idle
	task automatic do_reset();
		@(negedge clk);
		reset = 1'b1;
		layer_en = 1'b0;
		ifm = '0;
		ram_feedback = 1'b0;
		rd_addr = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
	endtask

	// Same seed every time so runs see the same stream
	task automatic fill_random_stream();
		lfsr_state = 16'd62;
		for (int p = 0; p < PIXELS; p++)
			for (int t = 0; t < TAPS; t++)
				stream[p][t] = data_t'(lfsr_take(16));
	endtask

	// Full-scale taps steered by weight signs
	task automatic fill_extreme_stream();
		data_t hi;
		data_t lo;
		hi = data_t'(16'h7FFF);
		lo = data_t'(16'h8000);
		for (int p = 0; p < PIXELS; p++) begin
			for (int t = 0; t < TAPS; t++) begin
				case (p % 4)
					0: stream[p][t] = hi;
					1: stream[p][t] = lo;
					// Lane 1 at its largest sum
					2: stream[p][t] = (weight_of(1, t) >= 0) ? hi : lo;
					// Lane 0 at its most negative sum
					default: stream[p][t] = (weight_of(0, t) >= 0) ? lo : hi;
				endcase
			end
		end
	endtask

	// One tap per enabled cycle with optional random gaps of junk on ifm
	task automatic feed_layer(input bit with_pauses);
		int gap;
		for (int p = 0; p < PIXELS; p++) begin
			for (int t = 0; t < TAPS; t++) begin
				gap = 0;
				if (with_pauses && lfsr_take(2) == 0)
					gap = 1 + int'(lfsr_take(2));
				repeat (gap) begin
					@(negedge clk);
					layer_en = 1'b0;
					ifm = data_t'(lfsr_take(16));
				end
				@(negedge clk);
				layer_en = 1'b1;
				ifm = stream[p][t];
			end
		end
		@(negedge clk);
		layer_en = 1'b0;
		ifm = '0;
	endtask

	task automatic wait_for_finish();
		int cycles;
		cycles = 0;
		while (finish !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout("finish");
		end
	endtask

	// rd_data lags rd_addr by one edge
	task automatic compare_store();
		ofm_vec_t exp_vec;
		for (int p = 0; p < PIXELS; p++) begin
			exp_vec = expected_vec(p);
			@(negedge clk);
			rd_addr = pix_idx_t'(p);
			@(negedge clk);
			for (int l = 0; l < LANES; l++)
				check_value($sformatf("rd_data[%0d] of pixel %0d", l, p), rd_data[l],
					exp_vec[l]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	// Idle layer with junk on ifm
	task automatic check_idle();
		do_reset();
		check_value("sample", sample, 1'b0);
		check_value("finish", finish, 1'b0);
		repeat (20) begin
			@(negedge clk);
			ifm = data_t'(lfsr_take(16));
			check_value("sample", sample, 1'b0);
			check_value("finish", finish, 1'b0);
		end
	endtask

	task automatic run_full_layer();
		do_reset();
		fill_random_stream();
		feed_layer(1'b0);
		wait_for_finish();
		check_value("sample_count", sample_count, PIXELS);
		compare_store();
	endtask

	// Same stream with gaps drawn after the fill
	task automatic run_paused_layer();
		do_reset();
		fill_random_stream();
		feed_layer(1'b1);
		wait_for_finish();
		check_value("sample_count", sample_count, PIXELS);
		compare_store();
	endtask

	task automatic run_extreme_values();
		do_reset();
		fill_extreme_stream();
		feed_layer(1'b0);
		wait_for_finish();
		compare_store();
	endtask

	task automatic check_finish_feedback();
		int cycles;
		do_reset();
		fill_random_stream();
		feed_layer(1'b0);
		// Ninth sample is the one seen while eight are counted
		cycles = 0;
		while (!(sample === 1'b1 && sample_count == PIXELS - 1)) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout("the last sample");
		end
		check_value("finish", finish, 1'b0);
		@(negedge clk);
		check_value("finish", finish, 1'b1);
		check_value("sample", sample, 1'b0);
		check_value("sample_count", sample_count, PIXELS);
		// Held while no feedback
		repeat (10) begin
			@(negedge clk);
			check_value("finish", finish, 1'b1);
		end
		ram_feedback = 1'b1;
		@(negedge clk);
		ram_feedback = 1'b0;
		check_value("finish", finish, 1'b0);
		// Extra taps must not wake the layer
		repeat (2 * TAPS) begin
			@(negedge clk);
			layer_en = 1'b1;
			ifm = data_t'(lfsr_take(16));
			check_value("sample", sample, 1'b0);
			check_value("finish", finish, 1'b0);
		end
		@(negedge clk);
		layer_en = 1'b0;
		repeat (8) begin
			@(negedge clk);
			check_value("sample", sample, 1'b0);
			check_value("finish", finish, 1'b0);
		end
		check_value("sample_count", sample_count, PIXELS);
	endtask

	initial begin
		reset = 1'b1;
		layer_en = 1'b0;
		ifm = '0;
		ram_feedback = 1'b0;
		rd_addr = '0;
		lfsr_state = 16'd62;
		check_idle();
		run_full_layer();
		run_paused_layer();
		run_extreme_values();
		check_finish_feedback();
		if (squeeze_top_inst.assertions_inst.fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+bench
logic/squeeze_pkg.sv
logic/weight_rom.sv
logic/mac_lane.sv
logic/squeeze_layer.sv
logic/ofm_store.sv
logic/squeeze_top.sv
bench/squeeze_assertions.sv
bench/squeeze_tb.sv
